/* hw/nfc_pkg.sv */
`default_nettype none

package nfc_pkg;

    localparam int BEAT_W = 64;
    localparam int NAND_W = 16;
    localparam int REG_W  = 32;
    localparam int REG_AW = 4;

    localparam int WORDS_PER_BEAT = BEAT_W / NAND_W;

    // row address goes out one byte per cycle
    localparam int ADDR_CYCLES = 3;

    typedef enum logic [3:0] {
        OP_PROGRAM = 4'h1,
        OP_ERASE   = 4'h6
    } opcode_e;

    typedef logic [3:0]  way_t;
    typedef logic [23:0] nand_addr_t;
    typedef logic [7:0]  beat_len_t;

    typedef struct packed {
        opcode_e    opcode;
        way_t       way;
        nand_addr_t addr;
        beat_len_t  len;
    } cmd_t;

    typedef enum logic [1:0] {
        RES_OK         = 2'd0,
        RES_BAD_OPCODE = 2'd1
    } result_e;

    typedef struct packed {
        opcode_e    opcode;
        way_t       way;
        result_e    result;
        logic [7:0] count;
    } status_t;

    // register word addresses
    localparam logic [REG_AW-1:0] REG_CMD    = 4'h0;
    localparam logic [REG_AW-1:0] REG_ADDR   = 4'h1;
    localparam logic [REG_AW-1:0] REG_STATUS = 4'h2;
    localparam logic [REG_AW-1:0] REG_RB     = 4'h3;

    // sticky command fail flag in REG_STATUS
    localparam int FAIL_BIT = 31;

endpackage

`default_nettype wire

/* hw/nfc_credit_fifo.sv */
`timescale 1ns/1ns
`default_nettype none

module nfc_credit_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 4
) (
    input  logic     s_axil_clk,
    input  logic     arst_n,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output logic     avail,
    output payload_t head,
    output logic     credit
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             do_pop;

    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign avail  = (count_q != '0);
    assign do_pop = pop && avail;
    assign head   = mem[rd_ptr_q];

    always_ff @(posedge s_axil_clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            credit   <= 1'b0;
        end else begin
            // credits keep the writer within DEPTH
            if (push) begin
                wr_ptr_q <= ptr_next(wr_ptr_q);
            end
            if (do_pop) begin
                rd_ptr_q <= ptr_next(rd_ptr_q);
            end
            if (push && !do_pop) begin
                count_q <= count_q + 1'b1;
            end else if (!push && do_pop) begin
                count_q <= count_q - 1'b1;
            end
            credit <= do_pop;
        end
    end

    always_ff @(posedge s_axil_clk) begin
        if (push) begin
            mem[wr_ptr_q] <= push_data;
        end
    end

endmodule

`default_nettype wire

/* hw/nfc_width_adapter.sv */
`timescale 1ns/1ns
`default_nettype none

module nfc_width_adapter (
    input  logic                       s_axil_clk,
    input  logic                       arst_n,
    input  logic                       beat_avail,
    input  logic [nfc_pkg::BEAT_W-1:0] beat,
    output logic                       beat_pop,
    output logic                       word_avail,
    output logic [nfc_pkg::NAND_W-1:0] word,
    input  logic                       word_take
);
    import nfc_pkg::*;

    localparam int IDX_W = $clog2(WORDS_PER_BEAT);

    logic [BEAT_W-1:0] beat_q;
    logic [IDX_W-1:0]  idx_q;
    logic              full_q;
    logic              take;
    logic              last_take;

    assign word_avail = full_q;
    assign word       = beat_q[idx_q*NAND_W +: NAND_W];
    assign take       = word_take && full_q;
    assign last_take  = take && (idx_q == IDX_W'(WORDS_PER_BEAT - 1));

    // refill in the same cycle the last word leaves
    assign beat_pop = beat_avail && (!full_q || last_take);

    always_ff @(posedge s_axil_clk or negedge arst_n) begin
        if (!arst_n) begin
            full_q <= 1'b0;
            idx_q  <= '0;
        end else begin
            if (beat_pop) begin
                full_q <= 1'b1;
                idx_q  <= '0;
            end else if (last_take) begin
                full_q <= 1'b0;
                idx_q  <= '0;
            end else if (take) begin
                idx_q <= idx_q + 1'b1;
            end
        end
    end

    always_ff @(posedge s_axil_clk) begin
        if (beat_pop) begin
            beat_q <= beat;
        end
    end

endmodule

`default_nettype wire

/* hw/nfc_way_engine.sv */
`timescale 1ns/1ns
`default_nettype none

module nfc_way_engine #(
    parameter int NUM_WAYS = 2
) (
    input  logic                       s_axil_clk,
    input  logic                       arst_n,
    input  logic                       cmd_avail,
    input  nfc_pkg::cmd_t              cmd,
    output logic                       cmd_pop,
    input  logic                       word_avail,
    input  logic [nfc_pkg::NAND_W-1:0] word,
    output logic                       word_take,
    input  logic [NUM_WAYS-1:0]        nand_rb,
    output logic [nfc_pkg::NAND_W-1:0] nand_dq,
    output logic                       nand_we,
    output logic                       nand_ale,
    output logic [NUM_WAYS-1:0]        nand_ce,
    output logic                       status_valid,
    output nfc_pkg::status_t           status
);
    import nfc_pkg::*;

    localparam int WAY_IDX_W = (NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1;
    localparam int WCNT_W    = $bits(beat_len_t) + $clog2(WORDS_PER_BEAT);

    typedef enum logic [2:0] {
        S_IDLE,
        S_WAIT_RB,
        S_ADDR,
        S_DATA,
        S_DONE
    } state_e;

    state_e               state_q;
    cmd_t                 cmd_q;
    logic                 bad_q;
    logic [1:0]           addr_cnt_q;
    logic [WCNT_W-1:0]    word_cnt_q;
    logic [WCNT_W-1:0]    word_last;
    logic [7:0]           done_cnt_q;
    logic [WAY_IDX_W-1:0] way_idx;
    logic                 op_ok;
    logic [7:0]           addr_byte;

    assign way_idx   = cmd_q.way[WAY_IDX_W-1:0];
    assign op_ok     = (cmd.opcode == OP_PROGRAM) || (cmd.opcode == OP_ERASE);
    assign addr_byte = cmd_q.addr[addr_cnt_q*8 +: 8];
    assign word_last = WCNT_W'(cmd_q.len * WORDS_PER_BEAT) - 1'b1;

    assign cmd_pop   = (state_q == S_IDLE) && cmd_avail;
    assign word_take = (state_q == S_DATA) && word_avail;
    assign nand_ale  = (state_q == S_ADDR);
    // we stays low while the data path runs dry
    assign nand_we   = nand_ale || word_take;

    always_comb begin
        nand_ce = '1;
        nand_dq = '0;
        if ((state_q == S_ADDR) || (state_q == S_DATA)) begin
            nand_ce[way_idx] = 1'b0;
        end
        if (state_q == S_ADDR) begin
            nand_dq = NAND_W'(addr_byte);
        end else if (word_take) begin
            nand_dq = word;
        end
    end

    always_ff @(posedge s_axil_clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q      <= S_IDLE;
            bad_q        <= 1'b0;
            addr_cnt_q   <= '0;
            word_cnt_q   <= '0;
            done_cnt_q   <= '0;
            status_valid <= 1'b0;
        end else begin
            status_valid <= 1'b0;
            case (state_q)
                S_IDLE: begin
                    if (cmd_avail) begin
                        bad_q   <= !op_ok;
                        state_q <= op_ok ? S_WAIT_RB : S_DONE;
                    end
                end
                S_WAIT_RB: begin
                    if (nand_rb[way_idx]) begin
                        addr_cnt_q <= '0;
                        state_q    <= S_ADDR;
                    end
                end
                S_ADDR: begin
                    addr_cnt_q <= addr_cnt_q + 1'b1;
                    if (addr_cnt_q == 2'(ADDR_CYCLES - 1)) begin
                        word_cnt_q <= '0;
                        if ((cmd_q.opcode == OP_PROGRAM) && (cmd_q.len != '0)) begin
                            state_q <= S_DATA;
                        end else begin
                            state_q <= S_DONE;
                        end
                    end
                end
                S_DATA: begin
                    if (word_take) begin
                        word_cnt_q <= word_cnt_q + 1'b1;
                        if (word_cnt_q == word_last) begin
                            state_q <= S_DONE;
                        end
                    end
                end
                S_DONE: begin
                    status_valid <= 1'b1;
                    done_cnt_q   <= done_cnt_q + 1'b1;
                    state_q      <= S_IDLE;
                end
                default: begin
                    state_q <= S_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge s_axil_clk) begin
        if (cmd_pop) begin
            cmd_q <= cmd;
        end
        if (state_q == S_DONE) begin
            status.opcode <= cmd_q.opcode;
            status.way    <= cmd_q.way;
            status.result <= bad_q ? RES_BAD_OPCODE : RES_OK;
            status.count  <= done_cnt_q + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* hw/nfc_cmd_regs.sv */
`timescale 1ns/1ns
`default_nettype none

module nfc_cmd_regs #(
    parameter int NUM_WAYS  = 2,
    parameter int CMD_DEPTH = 4
) (
    input  logic                       s_axil_clk,
    input  logic                       arst_n,
    input  logic                       reg_wr,
    input  logic                       reg_rd,
    input  logic [nfc_pkg::REG_AW-1:0] reg_addr,
    input  logic [nfc_pkg::REG_W-1:0]  reg_wdata,
    output logic [nfc_pkg::REG_W-1:0]  reg_rdata,
    output logic                       cmd_push,
    output nfc_pkg::cmd_t              cmd_data,
    input  logic                       cmd_credit,
    input  logic                       status_valid,
    input  nfc_pkg::status_t           status,
    input  logic [NUM_WAYS-1:0]        nand_rb
);
    import nfc_pkg::*;

    localparam int CRED_W = $clog2(CMD_DEPTH + 1);

    nand_addr_t        addr_q;
    logic [CRED_W-1:0] credit_q;
    logic              fail_q;
    status_t           status_q;
    logic              cmd_wr;
    logic              issue;
    logic [REG_W-1:0]  rd_mux;

    assign cmd_wr = reg_wr && (reg_addr == REG_CMD);
    assign issue  = cmd_wr && (credit_q != '0);

    always_comb begin
        rd_mux = '0;
        case (reg_addr)
            REG_ADDR: begin
                rd_mux[$bits(nand_addr_t)-1:0] = addr_q;
            end
            REG_STATUS: begin
                rd_mux[$bits(status_t)-1:0] = status_q;
                rd_mux[FAIL_BIT]            = fail_q;
            end
            REG_RB: begin
                rd_mux[NUM_WAYS-1:0] = nand_rb;
            end
            default: begin
                rd_mux = '0;
            end
        endcase
    end

    always_ff @(posedge s_axil_clk or negedge arst_n) begin
        if (!arst_n) begin
            addr_q    <= '0;
            credit_q  <= CRED_W'(CMD_DEPTH);
            fail_q    <= 1'b0;
            status_q  <= '0;
            cmd_push  <= 1'b0;
            reg_rdata <= '0;
        end else begin
            cmd_push <= issue;
            if (reg_wr && (reg_addr == REG_ADDR)) begin
                addr_q <= reg_wdata[$bits(nand_addr_t)-1:0];
            end
            // one credit out per issue, one back per popped command
            if (issue && !cmd_credit) begin
                credit_q <= credit_q - 1'b1;
            end else if (!issue && cmd_credit) begin
                credit_q <= credit_q + 1'b1;
            end
            if (reg_rd) begin
                reg_rdata <= rd_mux;
            end
            if (reg_rd && (reg_addr == REG_STATUS)) begin
                fail_q <= 1'b0;
            end
            // a new failure wins over a clearing read
            if (cmd_wr && (credit_q == '0)) begin
                fail_q <= 1'b1;
            end
            if (status_valid) begin
                status_q <= status;
            end
        end
    end

    always_ff @(posedge s_axil_clk) begin
        if (issue) begin
            cmd_data.opcode <= opcode_e'(reg_wdata[3:0]);
            cmd_data.way    <= reg_wdata[7:4];
            cmd_data.addr   <= addr_q;
            cmd_data.len    <= reg_wdata[15:8];
        end
    end

endmodule

`default_nettype wire

/* hw/nfc_bridge_top.sv */
`timescale 1ns/1ns
`default_nettype none

module nfc_bridge_top #(
    parameter int NUM_WAYS   = 2,
    parameter int CMD_DEPTH  = 4,
    parameter int DATA_DEPTH = 8
) (
    input  logic                       s_axil_clk,
    input  logic                       arst_n,
    input  logic                       reg_wr,
    input  logic                       reg_rd,
    input  logic [nfc_pkg::REG_AW-1:0] reg_addr,
    input  logic [nfc_pkg::REG_W-1:0]  reg_wdata,
    output logic [nfc_pkg::REG_W-1:0]  reg_rdata,
    input  logic                       wdata_valid,
    input  logic [nfc_pkg::BEAT_W-1:0] wdata,
    output logic                       wdata_credit,
    output logic [nfc_pkg::NAND_W-1:0] nand_dq,
    output logic                       nand_we,
    output logic                       nand_ale,
    output logic [NUM_WAYS-1:0]        nand_ce,
    input  logic [NUM_WAYS-1:0]        nand_rb
);
    import nfc_pkg::*;

    logic              cmd_push;
    cmd_t              cmd_data;
    logic              cmd_credit;
    logic              cmd_pop;
    logic              cmd_avail;
    cmd_t              cmd_head;
    logic              beat_pop;
    logic              beat_avail;
    logic [BEAT_W-1:0] beat;
    logic              word_avail;
    logic [NAND_W-1:0] word;
    logic              word_take;
    logic              status_valid;
    status_t           status;

    nfc_cmd_regs #(
        .NUM_WAYS  (NUM_WAYS),
        .CMD_DEPTH (CMD_DEPTH)
    ) u_cmd_regs (
        .s_axil_clk   (s_axil_clk),
        .arst_n       (arst_n),
        .reg_wr       (reg_wr),
        .reg_rd       (reg_rd),
        .reg_addr     (reg_addr),
        .reg_wdata    (reg_wdata),
        .reg_rdata    (reg_rdata),
        .cmd_push     (cmd_push),
        .cmd_data     (cmd_data),
        .cmd_credit   (cmd_credit),
        .status_valid (status_valid),
        .status       (status),
        .nand_rb      (nand_rb)
    );

    nfc_credit_fifo #(
        .payload_t (cmd_t),
        .DEPTH     (CMD_DEPTH)
    ) u_cmd_fifo (
        .s_axil_clk (s_axil_clk),
        .arst_n     (arst_n),
        .push       (cmd_push),
        .push_data  (cmd_data),
        .pop        (cmd_pop),
        .avail      (cmd_avail),
        .head       (cmd_head),
        .credit     (cmd_credit)
    );

    // data beats from the external source
    nfc_credit_fifo #(
        .payload_t (logic [BEAT_W-1:0]),
        .DEPTH     (DATA_DEPTH)
    ) u_data_fifo (
        .s_axil_clk (s_axil_clk),
        .arst_n     (arst_n),
        .push       (wdata_valid),
        .push_data  (wdata),
        .pop        (beat_pop),
        .avail      (beat_avail),
        .head       (beat),
        .credit     (wdata_credit)
    );

    nfc_width_adapter u_width_adapter (
        .s_axil_clk (s_axil_clk),
        .arst_n     (arst_n),
        .beat_avail (beat_avail),
        .beat       (beat),
        .beat_pop   (beat_pop),
        .word_avail (word_avail),
        .word       (word),
        .word_take  (word_take)
    );

    nfc_way_engine #(
        .NUM_WAYS (NUM_WAYS)
    ) u_way_engine (
        .s_axil_clk   (s_axil_clk),
        .arst_n       (arst_n),
        .cmd_avail    (cmd_avail),
        .cmd          (cmd_head),
        .cmd_pop      (cmd_pop),
        .word_avail   (word_avail),
        .word         (word),
        .word_take    (word_take),
        .nand_rb      (nand_rb),
        .nand_dq      (nand_dq),
        .nand_we      (nand_we),
        .nand_ale     (nand_ale),
        .nand_ce      (nand_ce),
        .status_valid (status_valid),
        .status       (status)
    );

endmodule

`default_nettype wire

/* test/nfc_checker.sv */
`timescale 1ns/1ns
`default_nettype none

module nfc_checker #(
    parameter int NUM_WAYS   = 2,
    parameter int DATA_DEPTH = 8
) (
    input  logic                       s_axil_clk,
    input  logic                       arst_n,
    input  logic                       reg_rd,
    input  logic [nfc_pkg::REG_AW-1:0] reg_addr,
    input  logic [nfc_pkg::REG_W-1:0]  reg_rdata,
    input  logic                       wdata_valid,
    input  logic                       wdata_credit,
    input  logic [nfc_pkg::NAND_W-1:0] nand_dq,
    input  logic                       nand_we,
    input  logic                       nand_ale,
    input  logic [NUM_WAYS-1:0]        nand_ce,
    input  logic [NUM_WAYS-1:0]        nand_rb
);
    import nfc_pkg::*;

    // expected entries carry the chip enables above the pin value
    localparam int ENT_W = NUM_WAYS + NAND_W;

    logic [ENT_W-1:0] exp_addr_q[$];
    logic [ENT_W-1:0] exp_word_q[$];
    logic [REG_W-1:0] exp_status_q[$];

    int               nand_errors = 0;
    int               reg_errors  = 0;
    int               src_errors  = 0;

    logic [ENT_W-1:0] ent;
    logic             rd_checked  = 1'b0;
    logic [REG_W-1:0] rd_exp      = '0;
    int               outstanding = 0;

    task automatic expect_addr(input logic [NUM_WAYS-1:0] ce, input logic [7:0] addr_byte);
        exp_addr_q.push_back({ce, 8'h00, addr_byte});
    endtask

    task automatic expect_word(input logic [NUM_WAYS-1:0] ce, input logic [NAND_W-1:0] value);
        exp_word_q.push_back({ce, value});
    endtask

    task automatic expect_status(input logic [REG_W-1:0] value);
        exp_status_q.push_back(value);
    endtask

    function automatic int pending();
        return exp_addr_q.size() + exp_word_q.size() + exp_status_q.size();
    endfunction

    // one strobe per NAND cycle
    always @(posedge s_axil_clk) begin
        if (arst_n && nand_we && nand_ale) begin
            if (exp_addr_q.size() == 0) begin
                $display("error %0t: address cycle %h with none expected", $time, nand_dq);
                nand_errors++;
            end else begin
                ent = exp_addr_q.pop_front();
                if ((nand_dq != ent[NAND_W-1:0]) || (nand_ce != ent[ENT_W-1:NAND_W])) begin
                    $display("error %0t: address cycle %h ce %b, expected %h ce %b", $time,
                             nand_dq, nand_ce, ent[NAND_W-1:0], ent[ENT_W-1:NAND_W]);
                    nand_errors++;
                end
            end
        end
        if (arst_n && nand_we && !nand_ale) begin
            if (exp_word_q.size() == 0) begin
                $display("error %0t: data word %h with none expected", $time, nand_dq);
                nand_errors++;
            end else begin
                ent = exp_word_q.pop_front();
                if ((nand_dq != ent[NAND_W-1:0]) || (nand_ce != ent[ENT_W-1:NAND_W])) begin
                    $display("error %0t: data word %h ce %b, expected %h ce %b", $time,
                             nand_dq, nand_ce, ent[NAND_W-1:0], ent[ENT_W-1:NAND_W]);
                    nand_errors++;
                end
            end
        end
    end

    // read data shows up one cycle after the strobe
    always @(posedge s_axil_clk) begin
        if (!arst_n) begin
            rd_checked = 1'b0;
        end else begin
            if (rd_checked && (reg_rdata != rd_exp)) begin
                $display("error %0t: register read %h, expected %h", $time, reg_rdata, rd_exp);
                reg_errors++;
            end
            rd_checked = 1'b0;
            if (reg_rd && (reg_addr == REG_RB)) begin
                rd_exp     = REG_W'(nand_rb);
                rd_checked = 1'b1;
            end else if (reg_rd && (reg_addr == REG_STATUS) && (exp_status_q.size() != 0)) begin
                rd_exp     = exp_status_q.pop_front();
                rd_checked = 1'b1;
            end
        end
    end

    // beats sent but not yet credited back
    always @(posedge s_axil_clk) begin
        if (!arst_n) begin
            outstanding = 0;
        end else begin
            outstanding = outstanding + (wdata_valid ? 1 : 0) - (wdata_credit ? 1 : 0);
            if (outstanding > DATA_DEPTH) begin
                $display("error %0t: source has %0d beats out with only %0d credits", $time,
                         outstanding, DATA_DEPTH);
                src_errors++;
            end
        end
    end

endmodule

`default_nettype wire

/* test/tb_nfc_bridge.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_nfc_bridge;
    import nfc_pkg::*;

    localparam int NUM_WAYS    = 2;
    localparam int CMD_DEPTH   = 4;
    localparam int DATA_DEPTH  = 8;
    localparam int POLL_LIMIT  = 500;
    localparam int DRAIN_LIMIT = 2000;

    logic                s_axil_clk  = 1'b0;
    logic                arst_n;
    logic                reg_wr;
    logic                reg_rd;
    logic [REG_AW-1:0]   reg_addr;
    logic [REG_W-1:0]    reg_wdata;
    logic [REG_W-1:0]    reg_rdata;
    logic                wdata_valid = 1'b0;
    logic [BEAT_W-1:0]   wdata       = '0;
    logic                wdata_credit;
    logic [NAND_W-1:0]   nand_dq;
    logic                nand_we;
    logic                nand_ale;
    logic [NUM_WAYS-1:0] nand_ce;
    logic [NUM_WAYS-1:0] nand_rb     = '1;

    logic [BEAT_W-1:0]   src_q[$];
    int                  src_credits = 0;
    logic                src_gaps;
    logic                rb_random;
    logic [NUM_WAYS-1:0] rb_hold;

    // model of the completion record
    logic [7:0]          exp_count;
    logic [17:0]         issued_status;
    logic [17:0]         last_status;
    int                  tb_errors;
    logic                timed_out;
    int unsigned         seed_val;
    int                  total;

    always #5 s_axil_clk = ~s_axil_clk;

    nfc_bridge_top #(
        .NUM_WAYS   (NUM_WAYS),
        .CMD_DEPTH  (CMD_DEPTH),
        .DATA_DEPTH (DATA_DEPTH)
    ) u_dut (
        .s_axil_clk   (s_axil_clk),
        .arst_n       (arst_n),
        .reg_wr       (reg_wr),
        .reg_rd       (reg_rd),
        .reg_addr     (reg_addr),
        .reg_wdata    (reg_wdata),
        .reg_rdata    (reg_rdata),
        .wdata_valid  (wdata_valid),
        .wdata        (wdata),
        .wdata_credit (wdata_credit),
        .nand_dq      (nand_dq),
        .nand_we      (nand_we),
        .nand_ale     (nand_ale),
        .nand_ce      (nand_ce),
        .nand_rb      (nand_rb)
    );

    nfc_checker #(
        .NUM_WAYS   (NUM_WAYS),
        .DATA_DEPTH (DATA_DEPTH)
    ) u_chk (
        .s_axil_clk   (s_axil_clk),
        .arst_n       (arst_n),
        .reg_rd       (reg_rd),
        .reg_addr     (reg_addr),
        .reg_rdata    (reg_rdata),
        .wdata_valid  (wdata_valid),
        .wdata_credit (wdata_credit),
        .nand_dq      (nand_dq),
        .nand_we      (nand_we),
        .nand_ale     (nand_ale),
        .nand_ce      (nand_ce),
        .nand_rb      (nand_rb)
    );

    // data source that sends only while it holds a credit
    always @(posedge s_axil_clk) begin
        if (!arst_n) begin
            src_credits = DATA_DEPTH;
            wdata_valid <= 1'b0;
        end else begin
            if (wdata_credit) begin
                src_credits = src_credits + 1;
            end
            if ((src_q.size() != 0) && (src_credits > 0)
                    && !(src_gaps && (($urandom % 3) == 0))) begin
                wdata       <= src_q.pop_front();
                wdata_valid <= 1'b1;
                src_credits = src_credits - 1;
            end else begin
                wdata_valid <= 1'b0;
            end
        end
    end

    always @(posedge s_axil_clk) begin
        for (int i = 0; i < NUM_WAYS; i++) begin
            if (!rb_random) begin
                nand_rb[i] <= rb_hold[i];
            end else if (($urandom % 8) == 0) begin
                nand_rb[i] <= !nand_rb[i];
            end
        end
    end

    task automatic reg_write(input logic [REG_AW-1:0] addr, input logic [REG_W-1:0] data);
        @(posedge s_axil_clk);
        reg_wr    <= 1'b1;
        reg_addr  <= addr;
        reg_wdata <= data;
        @(posedge s_axil_clk);
        reg_wr <= 1'b0;
    endtask

    task automatic reg_read(input logic [REG_AW-1:0] addr, output logic [REG_W-1:0] data);
        @(posedge s_axil_clk);
        reg_rd   <= 1'b1;
        reg_addr <= addr;
        @(posedge s_axil_clk);
        reg_rd <= 1'b0;
        @(negedge s_axil_clk);
        data = reg_rdata;
    endtask

    function automatic logic [3:0] random_bad_op();
        logic [3:0] op;
        op = 4'($urandom);
        if ((op == OP_PROGRAM) || (op == OP_ERASE)) begin
            op = 4'hf;
        end
        return op;
    endfunction

    // only accepted commands load the model
    task automatic issue_cmd(input logic [3:0] op, input int way, input int len,
                             input logic accepted);
        logic [23:0]         addr;
        logic [BEAT_W-1:0]   beat;
        logic [NUM_WAYS-1:0] ce;
        logic                valid_op;
        addr     = 24'($urandom);
        ce       = ~(NUM_WAYS'(1) << way);
        valid_op = (op == OP_PROGRAM) || (op == OP_ERASE);
        if (accepted) begin
            if (valid_op) begin
                for (int i = 0; i < 3; i++) begin
                    u_chk.expect_addr(ce, addr[i*8 +: 8]);
                end
            end
            if (op == OP_PROGRAM) begin
                for (int b = 0; b < len; b++) begin
                    beat = {$urandom, $urandom};
                    src_q.push_back(beat);
                    for (int w = 0; w < WORDS_PER_BEAT; w++) begin
                        u_chk.expect_word(ce, beat[w*NAND_W +: NAND_W]);
                    end
                end
            end
            exp_count     = exp_count + 8'd1;
            issued_status = {op, 4'(way), valid_op ? RES_OK : RES_BAD_OPCODE, exp_count};
        end
        reg_write(REG_ADDR, {8'h00, addr});
        reg_write(REG_CMD, {16'h0000, 8'(len), 4'(way), op});
    endtask

    task automatic wait_count(input logic [7:0] target);
        logic [REG_W-1:0] rd;
        int               polls;
        logic             done;
        if (timed_out) begin
            return;
        end
        done  = 1'b0;
        polls = 0;
        rd    = '0;
        while (!done && (polls < POLL_LIMIT)) begin
            reg_read(REG_RB, rd);
            reg_read(REG_STATUS, rd);
            done  = (rd[7:0] == target);
            polls = polls + 1;
        end
        if (done) begin
            last_status = issued_status;
        end else begin
            $display("timeout: completion count stuck at %0d while waiting for %0d",
                     rd[7:0], target);
            tb_errors = tb_errors + 1;
            timed_out = 1'b1;
        end
    endtask

    task automatic check_status(input logic fail);
        logic [REG_W-1:0] rd;
        u_chk.expect_status({fail, 13'd0, last_status});
        reg_read(REG_STATUS, rd);
    endtask

    task automatic check_drained(input string where);
        if (u_chk.pending() != 0) begin
            $display("after %s, %0d expected items never showed up", where, u_chk.pending());
            tb_errors = tb_errors + 1;
        end
    endtask

    task automatic run_cmd(input logic [3:0] op, input int way, input int len);
        issue_cmd(op, way, len, 1'b1);
        wait_count(exp_count);
        check_status(1'b0);
        check_drained("single command");
    endtask

    task automatic fill_while_busy();
        int way;
        way          = $urandom % NUM_WAYS;
        rb_hold[way] = 1'b0;
        issue_cmd(OP_ERASE, way, 0, 1'b1);
        // engine takes this one and its credit comes back
        repeat (4) @(posedge s_axil_clk);
        repeat (CMD_DEPTH) issue_cmd(OP_ERASE, way, $urandom % 4, 1'b1);
        issue_cmd(OP_ERASE, way, 0, 1'b0);
        check_status(1'b1);
        check_status(1'b0);
        rb_hold[way] = 1'b1;
        wait_count(exp_count);
        check_status(1'b0);
        check_drained("busy way released");
    endtask

    task automatic random_traffic();
        logic [3:0] op;
        rb_random = 1'b1;
        src_gaps  = 1'b1;
        repeat (4) begin
            repeat (CMD_DEPTH) begin
                op = (($urandom % 4) == 0) ? OP_ERASE : OP_PROGRAM;
                issue_cmd(op, $urandom % NUM_WAYS, 1 + $urandom % 4, 1'b1);
            end
            wait_count(exp_count);
            check_status(1'b0);
            check_drained("random traffic");
        end
        rb_random = 1'b0;
        src_gaps  = 1'b0;
        rb_hold   = '1;
    endtask

    task automatic wait_drained();
        int cycles;
        cycles = 0;
        while (((src_q.size() != 0) || (u_chk.pending() != 0)) && (cycles < DRAIN_LIMIT)) begin
            @(posedge s_axil_clk);
            cycles = cycles + 1;
        end
        if ((src_q.size() != 0) || (u_chk.pending() != 0)) begin
            $display("run ended with %0d beats unsent and %0d expected items missing",
                     src_q.size(), u_chk.pending());
            tb_errors = tb_errors + 1;
        end
    endtask

    initial begin
        seed_val      = $urandom(32'h36c2);
        arst_n        = 1'b0;
        reg_wr        = 1'b0;
        reg_rd        = 1'b0;
        reg_addr      = '0;
        reg_wdata     = '0;
        src_gaps      = 1'b0;
        rb_random     = 1'b0;
        rb_hold       = '1;
        exp_count     = '0;
        issued_status = '0;
        last_status   = '0;
        tb_errors     = 0;
        timed_out     = 1'b0;
        repeat (5) @(posedge s_axil_clk);
        arst_n <= 1'b1;

        repeat (6) run_cmd(OP_PROGRAM, $urandom % NUM_WAYS, 1 + $urandom % 4);
        run_cmd(OP_PROGRAM, $urandom % NUM_WAYS, 0);
        repeat (3) run_cmd(OP_ERASE, $urandom % NUM_WAYS, $urandom % 4);
        repeat (3) run_cmd(random_bad_op(), $urandom % NUM_WAYS, $urandom % 4);
        fill_while_busy();
        random_traffic();
        wait_drained();

        total = tb_errors + u_chk.nand_errors + u_chk.reg_errors + u_chk.src_errors;
        $display("errors: nand %0d, register %0d, source %0d, testbench %0d",
                 u_chk.nand_errors, u_chk.reg_errors, u_chk.src_errors, tb_errors);
        if (total == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* nfc_bridge_top.f */
hw/nfc_pkg.sv
hw/nfc_credit_fifo.sv
hw/nfc_width_adapter.sv
hw/nfc_way_engine.sv
hw/nfc_cmd_regs.sv
hw/nfc_bridge_top.sv
test/nfc_checker.sv
test/tb_nfc_bridge.sv

/* run_sim.sh */
#!/bin/sh
# builds the testbench with Verilator, runs it and scans the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --top-module tb_nfc_bridge \
    -f nfc_bridge_top.f --Mdir "$BUILD_DIR" -o sim_nfc
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/sim_nfc" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -qx "Test OK" "$LOG"; then
    exit 0
fi
exit 1
